//--- sim.f
rtl/tcb_pkg.sv
rtl/tcb_dec.sv
rtl/tcb_mem.sv
rtl/tcb_alu.sv
rtl/tcb_top.sv
dv/tcb_properties.sv
dv/tcb_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the TCB testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tcb_tb -f sim.f -o tcb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/tcb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- dv/tcb_tb.sv
`timescale 1ns/100ps

module tcb_tb;

////////////////////////////////////////////////////////////////////////////
// clock, reset, DUT
////////////////////////////////////////////////////////////////////////////

  logic              tcb = 1'b0;
  logic              rst_n;
  logic              vld;
  tcb_pkg::tcb_req_t req;
  logic              rdy;
  logic              rsp_vld;
  tcb_pkg::tcb_rsp_t rsp;

  // 4 ns period
  always #2 tcb = ~tcb;

  tcb_top UUT (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  // counters, totals and marks at the start of a test
  int          chk_cnt = 0;
  int          err_cnt = 0;
  int          chk_mark = 0;
  int          err_mark = 0;
  int          max_wait = 100;
  // cycles the last request spent waiting for rdy
  int          last_waits;
  logic [31:0] rng = 32'hb3a54c66;
  // expected responses in transfer order
  tcb_pkg::tcb_rsp_t exp_q[$];
  // memory words written so far
  logic [15:0] adr_q[$];
  // alu offsets that do not exist
  logic [15:0] bad_adr [4] = '{16'h8010, 16'h8002, 16'h8ffc, 16'hc004};

  // model state
  logic [31:0]      ref_mem [tcb_pkg::MEM_WORDS];
  logic [31:0]      ref_a;
  logic [31:0]      ref_b;
  logic [31:0]      ref_prod;
  tcb_pkg::alu_op_e ref_op = tcb_pkg::OP_ADD;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] random_word();
    rng = xorshift(rng);
    return rng;
  endfunction

////////////////////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////////////////////

  // expected response of one request, model updated as a side effect
  function automatic tcb_pkg::tcb_rsp_t ref_model(input tcb_pkg::tcb_req_t r);
    tcb_pkg::tcb_rsp_t e;
    logic [15:0]       off;
    logic [31:0]       res;
    e.rdt = '0;
    e.err = 1'b0;
    off   = {1'b0, r.adr[14:0]};
    // result follows the last opcode
    case (ref_op)
      tcb_pkg::OP_ADD: res = ref_a + ref_b;
      tcb_pkg::OP_SUB: res = ref_a - ref_b;
      tcb_pkg::OP_AND: res = ref_a & ref_b;
      default:         res = ref_prod;
    endcase
    if (r.adr[15]) begin
      if (off == tcb_pkg::REG_A) begin
        if (r.wen) ref_a = r.wdt;
        else e.rdt = ref_a;
      end else if (off == tcb_pkg::REG_B) begin
        if (r.wen) ref_b = r.wdt;
        else e.rdt = ref_b;
      end else if (off == tcb_pkg::REG_OP) begin
        if (r.wen) begin
          ref_op = tcb_pkg::alu_op_e'(r.wdt[1:0]);
          // low word of the product only
          if (ref_op == tcb_pkg::OP_MUL) ref_prod = ref_a * ref_b;
        end else begin
          e.rdt = {30'b0, ref_op};
        end
      end else if (off == tcb_pkg::REG_RES) begin
        if (r.wen) e.err = 1'b1;
        else e.rdt = res;
      end else begin
        e.err = 1'b1;
      end
    end else if (r.adr >= 16'(tcb_pkg::MEM_WORDS * 4)) begin
      e.err = 1'b1;
    end else if (r.wen) begin
      for (int b = 0; b < 4; b++) begin
        if (r.ben[b]) ref_mem[r.adr[tcb_pkg::MEM_AW+1:2]][8*b +: 8] = r.wdt[8*b +: 8];
      end
    end else begin
      e.rdt = ref_mem[r.adr[tcb_pkg::MEM_AW+1:2]];
    end
    return e;
  endfunction

////////////////////////////////////////////////////////////////////////////
// compare, sampled mid-cycle
////////////////////////////////////////////////////////////////////////////

  always @(negedge tcb) begin
    tcb_pkg::tcb_rsp_t exp;
    // response of the transfer at the last rising edge
    if (rst_n && (rsp_vld || exp_q.size() != 0)) begin
      chk_cnt++;
      assert (rsp_vld && exp_q.size() != 0) else begin
        err_cnt++;
        $display("** Error at %0t: rsp_vld %b with %0d responses due", $time, rsp_vld,
                 exp_q.size());
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        chk_cnt++;
        assert (rsp === exp) else begin
          err_cnt++;
          $display("** Error at %0t: rdt %h err %b, expected rdt %h err %b", $time,
                   rsp.rdt, rsp.err, exp.rdt, exp.err);
        end
      end
    end
    // transfer on the coming edge
    if (rst_n && vld && rdy) exp_q.push_back(ref_model(req));
  end

////////////////////////////////////////////////////////////////////////////
// bus driver
////////////////////////////////////////////////////////////////////////////

  // called on a rising edge, returns on the transfer edge
  task automatic bus_access(input logic wen, input logic [15:0] adr, input logic [3:0] ben,
                            input logic [31:0] wdt);
    tcb_pkg::tcb_req_t r;
    int                waits;
    r.wen = wen;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    vld   <= 1'b1;
    req   <= r;
    waits = 0;
    @(negedge tcb);
    while (!rdy && waits < max_wait) begin
      @(negedge tcb);
      waits++;
    end
    last_waits = waits;
    if (!rdy) begin
      $display("timeout: rdy stayed low for %0d cycles at address %h", waits, adr);
      $display("Checks failed");
      $finish;
    end else begin
      @(posedge tcb);
    end
  endtask

  // drop vld, let the last response arrive, report the test
  task automatic finish_test(input string name);
    int n;
    vld <= 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < max_wait) begin
      @(posedge tcb);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("response missing %0d cycles after the last transfer", n);
      $display("Checks failed");
      $finish;
    end else begin
      $display("test %s: %0d checks, %0d errors", name, chk_cnt - chk_mark,
               err_cnt - err_mark);
      chk_mark = chk_cnt;
      err_mark = err_cnt;
    end
  endtask

////////////////////////////////////////////////////////////////////////////
// tests
////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [15:0] adr;
    rst_n <= 1'b0;
    vld   <= 1'b0;
    req   <= '0;
    repeat (10) @(posedge tcb);
    rst_n <= 1'b1;
    @(posedge tcb);

    // random words, read back after all writes
    repeat (16) begin
      adr = 16'(random_word() & 32'h3fc);
      adr_q.push_back(adr);
      bus_access(1'b1, adr, 4'hf, random_word());
    end
    foreach (adr_q[i]) bus_access(1'b0, adr_q[i], 4'h0, '0);
    finish_test("memory write and read");

    // full word first, then a random mask
    repeat (16) begin
      adr = 16'(random_word() & 32'h3fc);
      bus_access(1'b1, adr, 4'hf, random_word());
      bus_access(1'b1, adr, 4'(random_word()), random_word());
      bus_access(1'b0, adr, 4'h0, '0);
    end
    finish_test("byte enables");

    bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_A, 4'hf, random_word());
    bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_B, 4'hf, random_word());
    // out of range, aliased onto a written word
    foreach (adr_q[i]) begin
      adr = adr_q[i] | 16'h0400 | (16'(random_word()) & 16'h7800);
      bus_access(1'b1, adr, 4'hf, random_word());
      bus_access(1'b0, adr, 4'h0, '0);
      bus_access(1'b0, adr_q[i], 4'h0, '0);
    end
    foreach (bad_adr[i]) begin
      bus_access(1'b1, bad_adr[i], 4'hf, random_word());
      bus_access(1'b0, bad_adr[i], 4'h0, '0);
    end
    // result is read only
    bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_RES, 4'hf, random_word());
    bus_access(1'b0, tcb_pkg::ALU_BASE | tcb_pkg::REG_A, 4'h0, '0);
    bus_access(1'b0, tcb_pkg::ALU_BASE | tcb_pkg::REG_B, 4'h0, '0);
    bus_access(1'b0, tcb_pkg::ALU_BASE | tcb_pkg::REG_RES, 4'h0, '0);
    finish_test("error responses");

    // add, sub, and in turn
    for (int k = 0; k < 24; k++) begin
      bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_A, 4'hf, random_word());
      bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_B, 4'hf, random_word());
      bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_OP, 4'hf, 32'(k % 3));
      bus_access(1'b0, tcb_pkg::ALU_BASE | tcb_pkg::REG_RES, 4'h0, '0);
    end
    finish_test("alu add sub and");

    repeat (4) begin
      bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_A, 4'hf, random_word());
      bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_B, 4'hf, random_word());
      bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_OP, 4'hf, 32'(tcb_pkg::OP_MUL));
      bus_access(1'b0, tcb_pkg::ALU_BASE | tcb_pkg::REG_RES, 4'h0, '0);
      // busy for all 32 steps
      chk_cnt++;
      assert (last_waits == 32) else begin
        err_cnt++;
        $display("** Error at %0t: result read held off %0d cycles, expected 32", $time,
                 last_waits);
      end
    end
    finish_test("alu multiply");

    // vld stays high across the whole run
    bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_OP, 4'hf, 32'(tcb_pkg::OP_SUB));
    repeat (16) begin
      adr = 16'(random_word() & 32'h3fc);
      bus_access(1'b1, adr, 4'hf, random_word());
      bus_access(1'b1, tcb_pkg::ALU_BASE | tcb_pkg::REG_A, 4'hf, random_word());
      bus_access(1'b0, adr, 4'h0, '0);
      bus_access(1'b0, tcb_pkg::ALU_BASE | tcb_pkg::REG_RES, 4'h0, '0);
    end
    finish_test("back to back");

    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- dv/tcb_properties.sv
`timescale 1ns/100ps

module tcb_properties (
  input logic              tcb,
  input logic              rst_n,
  input logic              vld,
  input tcb_pkg::tcb_req_t req,
  input logic              rdy,
  input logic              rsp_vld
);

////////////////////////////////////////////////////////////////////////////
// bus protocol at the top level
////////////////////////////////////////////////////////////////////////////

  // manager holds the request through wait states
  property req_held;
    @(posedge tcb) disable iff (!rst_n)
      (vld && !rdy) |=> (vld && $stable(req));
  endproperty

  // response flag one cycle after each transfer, never otherwise
  property rsp_after_transfer;
    @(posedge tcb) disable iff (!rst_n)
      rsp_vld == $past(vld && rdy);
  endproperty

  // first cycle out of reset is never ready
  property rdy_low_after_reset;
    @(posedge tcb) $rose(rst_n) |-> !rdy;
  endproperty

  req_held_a: assert property (req_held)
    else $error("request dropped or changed before rdy");

  rsp_after_transfer_a: assert property (rsp_after_transfer)
    else $error("rsp_vld not exactly one cycle after a transfer");

  rdy_low_after_reset_a: assert property (rdy_low_after_reset)
    else $error("rdy high in the first cycle after reset");

endmodule

bind tcb_top tcb_properties props (
  .tcb     (tcb),
  .rst_n   (rst_n),
  .vld     (vld),
  .req     (req),
  .rdy     (rdy),
  .rsp_vld (rsp_vld)
);

//--- rtl/tcb_top.sv
`timescale 1ns/100ps

module tcb_top (
  input  logic               tcb,
  input  logic               rst_n,
  input  logic               vld,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output logic               rsp_vld,
  output tcb_pkg::tcb_rsp_t  rsp
);

////////////////////////////////////////////////////////////////////////////
// subordinate links
////////////////////////////////////////////////////////////////////////////

  // memory port
  logic              mem_vld;
  logic              mem_rdy;
  tcb_pkg::tcb_rsp_t mem_rsp;

  // alu port
  logic              alu_vld;
  logic              alu_rdy;
  tcb_pkg::tcb_rsp_t alu_rsp;

  // region decode and response return
  tcb_dec dec (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .mem_vld (mem_vld),
    .mem_rdy (mem_rdy),
    .mem_rsp (mem_rsp),
    .alu_vld (alu_vld),
    .alu_rdy (alu_rdy),
    .alu_rsp (alu_rsp)
  );

  // both subordinates see the same request
  tcb_mem mem (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (mem_vld),
    .req   (req),
    .rdy   (mem_rdy),
    .rsp   (mem_rsp)
  );

  tcb_alu alu (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (alu_vld),
    .req   (req),
    .rdy   (alu_rdy),
    .rsp   (alu_rsp)
  );

endmodule

//--- rtl/tcb_alu.sv
`timescale 1ns/100ps

module tcb_alu (
  input  logic               tcb,
  input  logic               rst_n,
  input  logic               vld,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output tcb_pkg::tcb_rsp_t  rsp
);

////////////////////////////////////////////////////////////////////////////
// register decode
////////////////////////////////////////////////////////////////////////////

  // offset within the peripheral, region bit stripped
  logic [tcb_pkg::ABW-1:0] off;
  logic sel_a;
  logic sel_b;
  logic sel_op;
  logic sel_res;
  // unknown offset or write to the result
  logic acc_err;
  logic trn;

  assign off     = req.adr & ~tcb_pkg::ALU_BASE;
  assign sel_a   = (off == tcb_pkg::REG_A);
  assign sel_b   = (off == tcb_pkg::REG_B);
  assign sel_op  = (off == tcb_pkg::REG_OP);
  assign sel_res = (off == tcb_pkg::REG_RES);

  assign acc_err = ~(sel_a | sel_b | sel_op | sel_res) | (req.wen & sel_res);

  assign trn = vld & rdy;

////////////////////////////////////////////////////////////////////////////
// control
////////////////////////////////////////////////////////////////////////////

  logic                       rdy_q;
  tcb_pkg::alu_state_e        state;
  tcb_pkg::alu_op_e           op;
  tcb_pkg::alu_op_e           op_new;
  logic [tcb_pkg::MUL_CW-1:0] cnt;
  // opcode write, and one that starts a multiply
  logic                       wr_op;
  logic                       mul_go;

  assign op_new = tcb_pkg::alu_op_e'(req.wdt[1:0]);
  assign wr_op  = trn & req.wen & sel_op & ~acc_err;
  assign mul_go = wr_op & (op_new == tcb_pkg::OP_MUL);

  // held off for every request while multiplying
  assign rdy = rdy_q & (state == tcb_pkg::ST_IDLE);

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rdy_q <= 1'b0;
      state <= tcb_pkg::ST_IDLE;
      cnt   <= '0;
      op    <= tcb_pkg::OP_ADD;
    end else begin
      rdy_q <= 1'b1;
      case (state)
        tcb_pkg::ST_IDLE: begin
          if (mul_go) begin
            state <= tcb_pkg::ST_BUSY;
            cnt   <= '0;
          end
        end
        tcb_pkg::ST_BUSY: begin
          cnt <= cnt + 1'b1;
          // last of 32 steps
          if (cnt == tcb_pkg::MUL_CW'(tcb_pkg::DBW - 1)) begin
            state <= tcb_pkg::ST_IDLE;
          end
        end
        default: state <= tcb_pkg::ST_IDLE;
      endcase
      if (wr_op) begin
        op <= op_new;
      end
    end
  end

////////////////////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////////////////////

  // operands, whole word writes
  logic [tcb_pkg::DBW-1:0] a;
  logic [tcb_pkg::DBW-1:0] b;
  // multiplier working set
  logic [tcb_pkg::DBW-1:0] prod;
  logic [tcb_pkg::DBW-1:0] mcand;
  logic [tcb_pkg::DBW-1:0] mplier;
  logic [tcb_pkg::DBW-1:0] res;
  logic [tcb_pkg::DBW-1:0] rd_dat;

  always_ff @(posedge tcb) begin
    if (trn && req.wen && sel_a) begin
      a <= req.wdt;
    end
    if (trn && req.wen && sel_b) begin
      b <= req.wdt;
    end
    // shift-add, only the low word of the product is kept
    if (mul_go) begin
      prod   <= '0;
      mcand  <= a;
      mplier <= b;
    end else if (state == tcb_pkg::ST_BUSY) begin
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // simple ops follow the operands, multiply reads the product
  always_comb begin
    case (op)
      tcb_pkg::OP_ADD: res = a + b;
      tcb_pkg::OP_SUB: res = a - b;
      tcb_pkg::OP_AND: res = a & b;
      default:         res = prod;
    endcase
  end

  // register read mux
  always_comb begin
    rd_dat = '0;
    if (sel_a) begin
      rd_dat = a;
    end else if (sel_b) begin
      rd_dat = b;
    end else if (sel_op) begin
      rd_dat = {{(tcb_pkg::DBW-2){1'b0}}, op};
    end else if (sel_res) begin
      rd_dat = res;
    end
  end

  // response for the cycle after the transfer
  always_ff @(posedge tcb) begin
    if (trn) begin
      rsp.err <= acc_err;
      rsp.rdt <= (req.wen || acc_err) ? '0 : rd_dat;
    end
  end

endmodule

//--- rtl/tcb_mem.sv
`timescale 1ns/100ps

module tcb_mem (
  input  logic               tcb,
  input  logic               rst_n,
  input  logic               vld,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output tcb_pkg::tcb_rsp_t  rsp
);

////////////////////////////////////////////////////////////////////////////
// address check
////////////////////////////////////////////////////////////////////////////

  // word storage
  logic [tcb_pkg::DBW-1:0] mem [tcb_pkg::MEM_WORDS];

  // full word index, low two bits are the byte lane
  logic [tcb_pkg::ABW-3:0]    idx;
  // index into the array
  logic [tcb_pkg::MEM_AW-1:0] wid;
  logic                       in_range;
  logic                       trn;

  assign idx      = req.adr[tcb_pkg::ABW-1:2];
  assign wid      = idx[tcb_pkg::MEM_AW-1:0];
  // anything past the last word is an error
  assign in_range = (idx < tcb_pkg::MEM_WORDS);

  assign trn = vld & rdy;

////////////////////////////////////////////////////////////////////////////
// ready
////////////////////////////////////////////////////////////////////////////

  // low during reset and the cycle after, then always high
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

////////////////////////////////////////////////////////////////////////////
// access
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (trn) begin
      // byte lanes under their enables
      if (in_range && req.wen) begin
        for (int unsigned b = 0; b < tcb_pkg::BEW; b++) begin
          if (req.ben[b]) begin
            mem[wid][8*b +: 8] <= req.wdt[8*b +: 8];
          end
        end
      end
      // response for the next cycle
      rsp.err <= ~in_range;
      // writes and errors return zero data
      rsp.rdt <= (in_range && !req.wen) ? mem[wid] : '0;
    end
  end

endmodule

//--- rtl/tcb_dec.sv
`timescale 1ns/100ps

module tcb_dec (
  input  logic               tcb,
  input  logic               rst_n,
  // manager side
  input  logic               vld,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output logic               rsp_vld,
  output tcb_pkg::tcb_rsp_t  rsp,
  // memory subordinate
  output logic               mem_vld,
  input  logic               mem_rdy,
  input  tcb_pkg::tcb_rsp_t  mem_rsp,
  // alu subordinate
  output logic               alu_vld,
  input  logic               alu_rdy,
  input  tcb_pkg::tcb_rsp_t  alu_rsp
);

////////////////////////////////////////////////////////////////////////////
// request routing
////////////////////////////////////////////////////////////////////////////

  // region select, high for the alu
  logic sel;
  // select of the transfer now in its response cycle
  logic sel_q;
  // transfer on the manager side
  logic trn;

  // only the region bit matters here
  assign sel = |(req.adr & tcb_pkg::ALU_BASE);

  // valid goes to one subordinate only
  assign mem_vld = vld & ~sel;
  assign alu_vld = vld & sel;

  // ready of the addressed subordinate
  // alu back-pressure passes straight through
  assign rdy = sel ? alu_rdy : mem_rdy;

  assign trn = vld & rdy;

////////////////////////////////////////////////////////////////////////////
// response return
////////////////////////////////////////////////////////////////////////////

  // remember who took the transfer
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      sel_q   <= 1'b0;
      rsp_vld <= 1'b0;
    end else begin
      // response valid exactly one cycle after each transfer
      rsp_vld <= trn;
      if (trn) begin
        sel_q <= sel;
      end
    end
  end

  // steer the matching response back
  // both subordinates hold their last response, the mux picks one
  assign rsp = sel_q ? alu_rsp : mem_rsp;

endmodule

//--- rtl/tcb_pkg.sv
package tcb_pkg;

////////////////////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////////////////////

  // byte address width
  localparam int unsigned ABW = 16;
  // data width
  localparam int unsigned DBW = 32;
  // one enable per data byte
  localparam int unsigned BEW = DBW / 8;

  // memory size in words, 1 KiB
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

  // step counter width for the shift-add multiplier
  localparam int unsigned MUL_CW = $clog2(DBW);

////////////////////////////////////////////////////////////////////////////
// address map
////////////////////////////////////////////////////////////////////////////

  // bit 15 selects the arithmetic peripheral
  localparam logic [ABW-1:0] ALU_BASE = 16'h8000;

  // alu register offsets within the peripheral
  localparam logic [ABW-1:0] REG_A   = 16'h0000;
  localparam logic [ABW-1:0] REG_B   = 16'h0004;
  localparam logic [ABW-1:0] REG_OP  = 16'h0008;
  // result is read only
  localparam logic [ABW-1:0] REG_RES = 16'h000c;

////////////////////////////////////////////////////////////////////////////
// bus payload
////////////////////////////////////////////////////////////////////////////

  // request, 53 bits
  typedef struct packed {
    logic           wen;
    logic [ABW-1:0] adr;
    logic [BEW-1:0] ben;
    logic [DBW-1:0] wdt;
  } tcb_req_t;

  // response, 33 bits
  typedef struct packed {
    logic [DBW-1:0] rdt;
    logic           err;
  } tcb_rsp_t;

  // alu opcodes
  typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_AND, OP_MUL} alu_op_e;

  // multiplier states
  typedef enum logic {ST_IDLE, ST_BUSY} alu_state_e;

endpackage
